// ==== dv/cluster_periph_tb.sv ====
// Cluster peripheral testbench
module cluster_periph_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cluster_pkg::*;

  localparam int NB_CORES       = 4;
  localparam int CLK_PERIOD     = 10;
  localparam int GNT_LIMIT      = 16;
  localparam int CYCLES_PER_VEC = 200;

  logic                 clk_i;
  logic                 rst_i;
  logic                 req_i;
  word_t                add_i;
  logic                 wen_i;
  word_t                wdata_i;
  per_id_t              id_i;
  logic                 gnt_o;
  logic                 r_valid_o;
  word_t                r_rdata_o;
  per_id_t              r_id_o;
  logic [NB_CL_EVT-1:0] cluster_evt_i;
  logic                 soc_evt_valid_i;
  soc_evt_id_t          soc_evt_id_i;
  logic                 soc_evt_ready_o;
  logic                 eoc_o;
  logic [NB_CORES-1:0]  fetch_en_o;
  word_t [NB_CORES-1:0] boot_addr_o;
  logic [NB_CORES-1:0]  irq_o;

  // Vector table
  string vec_op[$];
  word_t vec_addr[$];
  word_t vec_data[$];
  word_t vec_exp[$];
  string vec_name[$];
  int    nb_vectors;
  int    nb_checks;

  // DUT outputs sampled at the falling edge
  logic    gnt_s;
  logic    rvalid_s;
  word_t   rdata_s;
  per_id_t rid_s;
  logic    soc_take;

  per_id_t     next_tag;
  soc_evt_id_t soc_exp_id;
  integer      seed;

  cluster_periph_top #(
    .NB_CORES  ( NB_CORES          ),
    .BOOT_ADDR ( DEFAULT_BOOT_ADDR )
  ) UUT (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .req_i           ( req_i           ),
    .add_i           ( add_i           ),
    .wen_i           ( wen_i           ),
    .wdata_i         ( wdata_i         ),
    .id_i            ( id_i            ),
    .gnt_o           ( gnt_o           ),
    .r_valid_o       ( r_valid_o       ),
    .r_rdata_o       ( r_rdata_o       ),
    .r_id_o          ( r_id_o          ),
    .cluster_evt_i   ( cluster_evt_i   ),
    .soc_evt_valid_i ( soc_evt_valid_i ),
    .soc_evt_id_i    ( soc_evt_id_i    ),
    .soc_evt_ready_o ( soc_evt_ready_o ),
    .eoc_o           ( eoc_o           ),
    .fetch_en_o      ( fetch_en_o      ),
    .boot_addr_o     ( boot_addr_o     ),
    .irq_o           ( irq_o           )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //************************************************************
  // Checking helpers
  //************************************************************
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    nb_checks++;
    assert (act === exp) else
      fail_run($sformatf("Mismatch %s: expected %08h, actual %08h", name, exp, act));
  endtask

  // One clock cycle, inputs change 1 ns after the rising edge
  task automatic clock_step();
    @(negedge clk_i);
    gnt_s    = gnt_o;
    rvalid_s = r_valid_o;
    rdata_s  = r_rdata_o;
    rid_s    = r_id_o;
    soc_take = soc_evt_valid_i && soc_evt_ready_o;
    @(posedge clk_i);
    #1;
    // Event taken on this edge, so release the handshake
    if (soc_take) begin
      soc_exp_id      = soc_evt_id_i;
      soc_evt_valid_i = 1'b0;
    end
  endtask

  //************************************************************
  // Bus and event drivers
  //************************************************************
  task automatic bus_access(input logic is_read, input word_t addr, input word_t wdata,
                            input string name, output word_t rdata);
    per_id_t tag;
    int      waited;
    tag      = next_tag;
    next_tag = next_tag + 5'd1;
    req_i    = 1'b1;
    add_i    = addr;
    wen_i    = is_read;
    wdata_i  = wdata;
    id_i     = tag;
    waited   = 0;
    clock_step();
    while (!gnt_s && waited < GNT_LIMIT) begin
      clock_step();
      waited++;
    end
    assert (gnt_s) else
      fail_run($sformatf("No grant for %s after %0d cycles", name, GNT_LIMIT));
    req_i = 1'b0;
    // Response is due exactly one cycle after the grant
    clock_step();
    assert (rvalid_s) else
      fail_run($sformatf("No response for %s one cycle after the grant", name));
    check_value({name, ".r_id"}, word_t'(tag), word_t'(rid_s));
    if (!is_read) begin
      check_value({name, ".wr_rdata"}, 32'h0, rdata_s);
    end
    rdata = rdata_s;
  endtask

  task automatic pulse_events(input logic [NB_CL_EVT-1:0] evts);
    cluster_evt_i = evts;
    clock_step();
    cluster_evt_i = '0;
  endtask

  task automatic send_soc_event(input int bound, input logic accept, input string name);
    int          waited;
    int          rnd;
    soc_evt_id_t id;
    rnd = $random(seed);
    id  = rnd[7:0];
    // Distinct ids let the readback tell two events apart
    while (id == soc_exp_id) begin
      rnd = $random(seed);
      id  = rnd[7:0];
    end
    soc_evt_id_i    = id;
    soc_evt_valid_i = 1'b1;
    waited          = 0;
    while (soc_evt_valid_i && waited < bound) begin
      clock_step();
      waited++;
    end
    if (accept) begin
      assert (!soc_evt_valid_i) else
        fail_run($sformatf("SoC event %s was not accepted within %0d cycles", name, bound));
    end else begin
      assert (soc_evt_valid_i) else
        fail_run($sformatf("SoC event %s was accepted while another was pending", name));
    end
  endtask

  task automatic wait_irq(input word_t exp, input int bound, input string name);
    int waited;
    waited = 0;
    while (irq_o !== exp[NB_CORES-1:0] && waited < bound) begin
      clock_step();
      waited++;
    end
    check_value(name, exp, word_t'(irq_o));
  endtask

  // Selector 0 eoc, 1 fetch enable, 2 boot address of one core, 3 irq, 4 SoC ready
  task automatic check_output(input word_t sel, input word_t core, input word_t exp,
                              input string name);
    word_t act;
    act = '0;
    case (sel)
      0: act = word_t'(eoc_o);
      1: act = word_t'(fetch_en_o);
      2: begin
        assert (core < NB_CORES) else
          fail_run($sformatf("Core %0d in %s does not exist", core, name));
        for (int c = 0; c < NB_CORES; c++) begin
          if (c == int'(core)) begin
            act = boot_addr_o[c];
          end
        end
      end
      3: act = word_t'(irq_o);
      4: act = word_t'(soc_evt_ready_o);
      default: fail_run($sformatf("Unknown output selector %0d in %s", sel, name));
    endcase
    check_value(name, exp, act);
  endtask

  //************************************************************
  // Vector file
  //************************************************************
  task automatic read_vectors();
    int    fd;
    int    n;
    string line;
    string op;
    string name;
    word_t a;
    word_t d;
    word_t e;
    fd = $fopen("dv/periph_vectors.txt", "r");
    assert (fd != 0) else
      fail_run("Cannot open the vector file dv/periph_vectors.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %s", op, a, d, e, name);
        if (n == 5) begin
          vec_op.push_back(op);
          vec_addr.push_back(a);
          vec_data.push_back(d);
          vec_exp.push_back(e);
          vec_name.push_back(name);
        end else if (n > 0) begin
          fail_run({"Malformed vector line: ", line});
        end
      end
    end
    $fclose(fd);
    assert (vec_op.size() > 0) else
      fail_run("The vector file holds no operations");
    nb_vectors = vec_op.size();
  endtask

  task automatic run_vector(input int i);
    word_t rdata;
    string op;
    string name;
    op   = vec_op[i];
    name = vec_name[i];
    if (op == "WR") begin
      bus_access(1'b0, vec_addr[i], vec_data[i], name, rdata);
    end else if (op == "RD") begin
      bus_access(1'b1, vec_addr[i], 32'h0, name, rdata);
      check_value(name, vec_exp[i], rdata);
    end else if (op == "EVT") begin
      pulse_events(vec_data[i][NB_CL_EVT-1:0]);
    end else if (op == "SOC") begin
      send_soc_event(int'(vec_data[i]), vec_exp[i][0], name);
    end else if (op == "IRQ") begin
      wait_irq(vec_exp[i], int'(vec_data[i]), name);
    end else if (op == "OUT") begin
      check_output(vec_addr[i], vec_data[i], vec_exp[i], name);
    end else if (op == "SID") begin
      assert (!soc_evt_valid_i) else
        fail_run($sformatf("SoC event still waiting at readback %s", name));
      bus_access(1'b1, vec_addr[i], 32'h0, name, rdata);
      check_value(name, word_t'(soc_exp_id), rdata);
    end else begin
      fail_run({"Unknown opcode ", op, " in ", name});
    end
  endtask

  //************************************************************
  // Main sequence and watchdog
  //************************************************************
  initial begin : main_seq
    seed            = 32'h43d5;
    rst_i           = 1'b1;
    req_i           = 1'b0;
    add_i           = '0;
    wen_i           = 1'b1;
    wdata_i         = '0;
    id_i            = '0;
    cluster_evt_i   = '0;
    soc_evt_valid_i = 1'b0;
    soc_evt_id_i    = '0;
    nb_checks       = 0;
    next_tag        = '0;
    soc_exp_id      = '0;
    read_vectors();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int i = 0; i < nb_vectors; i++) begin
      run_vector(i);
    end
    if (nb_checks == 0) begin
      fail_run("No check was run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  initial begin : watchdog
    wait (nb_vectors > 0);
    #(nb_vectors * CYCLES_PER_VEC * CLK_PERIOD);
    fail_run($sformatf("Timeout after %0d cycles", nb_vectors * CYCLES_PER_VEC));
  end

endmodule

// ==== dv/periph_vectors.txt ====
# opcode address data expected name, numbers in hex; SOC and IRQ take a cycle bound in data
# OUT address picks 0 eoc, 1 fetch_en, 2 boot_addr (data is the core), 3 irq, 4 soc_ready
OUT 0 0 0 reset_eoc
OUT 1 0 0 reset_fetch_en
OUT 3 0 0 reset_irq
OUT 4 0 1 reset_soc_ready
OUT 2 0 1C000000 reset_boot_out0
OUT 2 3 1C000000 reset_boot_out3
RD 040 0 1C000000 reset_boot0
RD 044 0 1C000000 reset_boot1
RD 048 0 1C000000 reset_boot2
RD 04C 0 1C000000 reset_boot3
RD 840 0 0 reset_pending
# Control unit
WR 008 5 0 ctrl_fetch_wr
OUT 1 0 5 ctrl_fetch_out
RD 008 0 5 ctrl_fetch_rd
WR 000 1 0 ctrl_eoc_wr
OUT 0 0 1 ctrl_eoc_out
RD 000 0 1 ctrl_eoc_rd
WR 040 1C008000 0 ctrl_boot0_wr
WR 044 1C008100 0 ctrl_boot1_wr
WR 048 1C008200 0 ctrl_boot2_wr
WR 04C 1C008300 0 ctrl_boot3_wr
OUT 2 0 1C008000 ctrl_boot0_out
OUT 2 1 1C008100 ctrl_boot1_out
OUT 2 2 1C008200 ctrl_boot2_out
OUT 2 3 1C008300 ctrl_boot3_out
RD 040 0 1C008000 ctrl_boot0_rd
RD 044 0 1C008100 ctrl_boot1_rd
RD 048 0 1C008200 ctrl_boot2_rd
RD 04C 0 1C008300 ctrl_boot3_rd
# Per-core masks
WR 800 03 0 mask_core0
WR 804 06 0 mask_core1
WR 808 18 0 mask_core2
WR 80C 81 0 mask_core3
RD 80C 0 81 mask_core3_rd
# Timer, count 5 up to compare 20
WR 404 5 0 tmr_count_wr
WR 408 20 0 tmr_cmp_wr
RD 404 0 5 tmr_count_rd
RD 408 0 20 tmr_cmp_rd
WR 400 3 0 tmr_enable
IRQ 0 2A 9 tmr_irq
WR 400 0 0 tmr_disable
RD 840 0 1 tmr_pending
WR 844 1 0 tmr_clear
RD 840 0 0 tmr_pending_clear
IRQ 0 4 0 tmr_irq_low
# External events and clearing
EVT 0 2 0 evt_pulse_a
IRQ 0 4 2 evt_irq_a
EVT 0 4 0 evt_pulse_b
IRQ 0 4 6 evt_irq_b
EVT 0 1 0 evt_pulse_c
IRQ 0 4 7 evt_irq_c
RD 840 0 E evt_pending
WR 844 6 0 evt_clear_a
RD 840 0 8 evt_pending_a
IRQ 0 4 4 evt_irq_clear_a
WR 844 8 0 evt_clear_b
RD 840 0 0 evt_pending_b
IRQ 0 4 0 evt_irq_clear_b
# SoC event handshake
SOC 0 A 1 soc_first
RD 840 0 80 soc_pending
SID 848 0 0 soc_id_first
OUT 4 0 0 soc_ready_low
IRQ 0 4 8 soc_irq
SOC 0 8 0 soc_second_waits
OUT 4 0 0 soc_ready_still_low
WR 844 80 0 soc_clear
RD 840 0 80 soc_second_pending
SID 848 0 0 soc_id_second
WR 844 80 0 soc_clear_final
IRQ 0 4 0 soc_irq_low
# Unmapped region
RD C00 0 DEADB33F unm_read
WR C08 12345678 0 unm_write
RD 008 0 5 unm_fetch_kept
OUT 1 0 5 unm_fetch_out
RD 408 0 20 unm_cmp_kept
RD 80C 0 81 unm_mask_kept

// ==== list.f ====
verilog/cluster_pkg.sv
verilog/periph_map_pkg.sv
verilog/periph_bus_if.sv
verilog/periph_bus_demux.sv
verilog/cluster_ctrl_unit.sv
verilog/cluster_timer.sv
verilog/event_unit.sv
verilog/cluster_periph_top.sv
dv/cluster_periph_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cluster peripheral regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cluster_periph_tb -f list.f

./obj_dir/Vcluster_periph_tb | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// ==== verilog/cluster_ctrl_unit.sv ====
// Cluster control registers
module cluster_ctrl_unit #(
  parameter int                 NB_CORES  = 4,
  parameter cluster_pkg::word_t BOOT_ADDR = cluster_pkg::DEFAULT_BOOT_ADDR
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  periph_bus_if.slave                        bus,
  output logic                               eoc_o,
  output logic [NB_CORES-1:0]                fetch_en_o,
  output cluster_pkg::word_t [NB_CORES-1:0]  boot_addr_o
);
  import cluster_pkg::*;
  import periph_map_pkg::*;

  offs_t      off;
  logic       wr;
  logic       boot_hit;
  logic [2:0] core_idx;
  word_t      rdata;

  assign off      = bus.add[SLV_SEL_LSB-1:0];
  assign bus.gnt  = bus.req;
  assign wr       = bus.req && !bus.wen;
  // Boot address block covers 0x40 to 0x5C, one word per core
  assign boot_hit = (off[9:5] == CTRL_BOOT_ADDR[9:5]);
  assign core_idx = off[4:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_o       <= 1'b0;
      fetch_en_o  <= '0;
      boot_addr_o <= {NB_CORES{BOOT_ADDR}};
    end else if (wr) begin
      if (off == CTRL_EOC) begin
        eoc_o <= bus.wdata[0];
      end
      if (off == CTRL_FETCH_EN) begin
        fetch_en_o <= bus.wdata[NB_CORES-1:0];
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (boot_hit && int'(core_idx) == c) begin
          boot_addr_o[c] <= bus.wdata;
        end
      end
    end
  end

  // Read mux, cores past NB_CORES read as zero
  always_comb begin
    rdata = '0;
    if (off == CTRL_EOC) begin
      rdata[0] = eoc_o;
    end else if (off == CTRL_FETCH_EN) begin
      rdata[NB_CORES-1:0] = fetch_en_o;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (boot_hit && int'(core_idx) == c) begin
          rdata = boot_addr_o[c];
        end
      end
    end
  end

  //************************************************************
  // Response
  //************************************************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bus.r_id    <= bus.id;
      bus.r_rdata <= bus.wen ? rdata : '0;
    end
  end

endmodule

// ==== verilog/cluster_periph_top.sv ====
// Cluster peripheral block
module cluster_periph_top #(
  parameter int                 NB_CORES  = 4,
  parameter cluster_pkg::word_t BOOT_ADDR = cluster_pkg::DEFAULT_BOOT_ADDR
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Peripheral bus
  input  logic                               req_i,
  input  cluster_pkg::word_t                 add_i,
  input  logic                               wen_i,
  input  cluster_pkg::word_t                 wdata_i,
  input  cluster_pkg::per_id_t               id_i,
  output logic                               gnt_o,
  output logic                               r_valid_o,
  output cluster_pkg::word_t                 r_rdata_o,
  output cluster_pkg::per_id_t               r_id_o,
  // Event sources
  input  logic [cluster_pkg::NB_CL_EVT-1:0]  cluster_evt_i,
  input  logic                               soc_evt_valid_i,
  input  cluster_pkg::soc_evt_id_t           soc_evt_id_i,
  output logic                               soc_evt_ready_o,
  // Core control
  output logic                               eoc_o,
  output logic [NB_CORES-1:0]                fetch_en_o,
  output cluster_pkg::word_t [NB_CORES-1:0]  boot_addr_o,
  output logic [NB_CORES-1:0]                irq_o
);

  periph_bus_if bus_in   ();
  periph_bus_if bus_ctrl ();
  periph_bus_if bus_tmr  ();
  periph_bus_if bus_evt  ();

  logic timer_evt;

  assign bus_in.req   = req_i;
  assign bus_in.add   = add_i;
  assign bus_in.wen   = wen_i;
  assign bus_in.wdata = wdata_i;
  assign bus_in.id    = id_i;
  assign gnt_o        = bus_in.gnt;
  assign r_valid_o    = bus_in.r_valid;
  assign r_rdata_o    = bus_in.r_rdata;
  assign r_id_o       = bus_in.r_id;

  periph_bus_demux demux_i (
    .clk_i  ( clk_i    ),
    .rst_i  ( rst_i    ),
    .slv    ( bus_in   ),
    .m_ctrl ( bus_ctrl ),
    .m_tmr  ( bus_tmr  ),
    .m_evt  ( bus_evt  )
  );

  cluster_ctrl_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) ctrl_unit_i (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .bus         ( bus_ctrl    ),
    .eoc_o       ( eoc_o       ),
    .fetch_en_o  ( fetch_en_o  ),
    .boot_addr_o ( boot_addr_o )
  );

  cluster_timer timer_i (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .bus         ( bus_tmr   ),
    .timer_evt_o ( timer_evt )
  );

  event_unit #(
    .NB_CORES ( NB_CORES )
  ) event_unit_i (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .bus             ( bus_evt         ),
    .timer_evt_i     ( timer_evt       ),
    .cluster_evt_i   ( cluster_evt_i   ),
    .soc_evt_valid_i ( soc_evt_valid_i ),
    .soc_evt_id_i    ( soc_evt_id_i    ),
    .soc_evt_ready_o ( soc_evt_ready_o ),
    .irq_o           ( irq_o           )
  );

endmodule

// ==== verilog/cluster_pkg.sv ====
// Cluster-wide types and constants
package cluster_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Requester tag echoed on the response
  typedef logic [4:0] per_id_t;

  // Cluster event sources, one bit each
  typedef logic [7:0] evt_t;

  // Identifier carried by a SoC event
  typedef logic [7:0] soc_evt_id_t;

  // Event bit positions
  localparam int EVT_TIMER  = 0;
  localparam int EVT_CL_LSB = 1;
  localparam int NB_CL_EVT  = 6;
  localparam int EVT_SOC    = 7;

  // Reset value of the per-core boot address registers
  localparam word_t DEFAULT_BOOT_ADDR = 32'h1C00_0000;

endpackage

// ==== verilog/cluster_timer.sv ====
// Cluster timer
module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_i,
  periph_bus_if.slave bus,
  output logic        timer_evt_o
);
  import cluster_pkg::*;
  import periph_map_pkg::*;

  offs_t off;
  logic  wr;
  logic  enable_q;
  logic  auto_clr_q;
  word_t count_q;
  word_t cmp_q;
  logic  match;
  word_t rdata;

  assign off     = bus.add[SLV_SEL_LSB-1:0];
  assign bus.gnt = bus.req;
  assign wr      = bus.req && !bus.wen;

  // Match is visible in the same cycle the count reaches compare
  assign match       = enable_q && (count_q == cmp_q);
  assign timer_evt_o = match;

  //************************************************************
  // Counter and configuration
  //************************************************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q   <= 1'b0;
      auto_clr_q <= 1'b0;
      count_q    <= '0;
      cmp_q      <= '0;
    end else begin
      // Software preload takes priority over counting
      if (wr && off == TMR_COUNT) begin
        count_q <= bus.wdata;
      end else if (match && auto_clr_q) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end

      if (wr && off == TMR_CFG) begin
        enable_q   <= bus.wdata[0];
        auto_clr_q <= bus.wdata[1];
      end
      if (wr && off == TMR_CMP) begin
        cmp_q <= bus.wdata;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (off)
      TMR_CFG:   rdata[1:0] = {auto_clr_q, enable_q};
      TMR_COUNT: rdata      = count_q;
      TMR_CMP:   rdata      = cmp_q;
      default:   rdata      = '0;
    endcase
  end

  //************************************************************
  // Response
  //************************************************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      bus.r_id    <= bus.id;
      bus.r_rdata <= bus.wen ? rdata : '0;
    end
  end

  // Auto-clear keeps the count inside the compare range
  a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    (auto_clr_q && (count_q <= cmp_q) && !wr) |=> (count_q <= cmp_q));

endmodule

// ==== verilog/event_unit.sv ====
// Cluster event unit
module event_unit #(
  parameter int NB_CORES = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  periph_bus_if.slave                         bus,
  input  logic                                timer_evt_i,
  input  logic [cluster_pkg::NB_CL_EVT-1:0]   cluster_evt_i,
  input  logic                                soc_evt_valid_i,
  input  cluster_pkg::soc_evt_id_t            soc_evt_id_i,
  output logic                                soc_evt_ready_o,
  output logic [NB_CORES-1:0]                 irq_o
);
  import cluster_pkg::*;
  import periph_map_pkg::*;

  offs_t                 off;
  logic                  acc;
  logic                  wr;
  logic                  soc_acc;
  logic                  mask_hit;
  logic [2:0]            core_idx;
  evt_t                  pending_q;
  evt_t                  evt_set;
  evt_t                  evt_clr;
  evt_t [NB_CORES-1:0]   mask_q;
  soc_evt_id_t           soc_id_q;
  word_t                 rdata;

  assign off      = bus.add[SLV_SEL_LSB-1:0];
  assign mask_hit = (off[9:5] == EU_MASK[9:5]);
  assign core_idx = off[4:2];

  // One SoC event in flight at a time
  assign soc_evt_ready_o = !pending_q[EVT_SOC];
  assign soc_acc         = soc_evt_valid_i && soc_evt_ready_o;

  // SoC intake wins over bus access in the same cycle
  assign bus.gnt = bus.req && !soc_acc;
  assign acc     = bus.req && bus.gnt;
  assign wr      = acc && !bus.wen;

  //************************************************************
  // Pending buffer
  //************************************************************
  always_comb begin
    evt_set                           = '0;
    evt_set[EVT_TIMER]                = timer_evt_i;
    evt_set[EVT_CL_LSB +: NB_CL_EVT]  = cluster_evt_i;
    evt_set[EVT_SOC]                  = soc_acc;
  end

  assign evt_clr = (wr && off == EU_CLEAR) ? bus.wdata[$bits(evt_t)-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      mask_q    <= '0;
      irq_o     <= '0;
    end else begin
      pending_q <= (pending_q & ~evt_clr) | evt_set;
      for (int c = 0; c < NB_CORES; c++) begin
        irq_o[c] <= |(pending_q & mask_q[c]);
        if (wr && mask_hit && int'(core_idx) == c) begin
          mask_q[c] <= bus.wdata[$bits(evt_t)-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (soc_acc) begin
      soc_id_q <= soc_evt_id_i;
    end
  end

  always_comb begin
    rdata = '0;
    if (off == EU_PENDING) begin
      rdata[$bits(evt_t)-1:0] = pending_q;
    end else if (off == EU_SOC_ID) begin
      rdata[$bits(soc_evt_id_t)-1:0] = soc_id_q;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (mask_hit && int'(core_idx) == c) begin
          rdata[$bits(evt_t)-1:0] = mask_q[c];
        end
      end
    end
  end

  //************************************************************
  // Response
  //************************************************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.r_valid <= 1'b0;
    end else begin
      bus.r_valid <= acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      bus.r_id    <= bus.id;
      bus.r_rdata <= bus.wen ? rdata : '0;
    end
  end

  // An accepted SoC event stays pending and blocks the next one
  a_soc_single: assert property (@(posedge clk_i) disable iff (rst_i)
    soc_acc |=> (pending_q[EVT_SOC] && !soc_acc));

endmodule

// ==== verilog/periph_bus_demux.sv ====
// Peripheral bus decoder
module periph_bus_demux (
  input  logic         clk_i,
  input  logic         rst_i,
  periph_bus_if.slave  slv,
  periph_bus_if.master m_ctrl,
  periph_bus_if.master m_tmr,
  periph_bus_if.master m_evt
);
  import cluster_pkg::*;
  import periph_map_pkg::*;

  slave_sel_t sel;
  slave_sel_t sel_q;
  logic       unm_q;
  logic       unm_wen_q;
  per_id_t    unm_id_q;

  assign sel = slv.add[SLV_SEL_LSB +: 2];

  //************************************************************
  // Request path
  //************************************************************
  assign m_ctrl.req   = slv.req && (sel == SLV_CTRL);
  assign m_ctrl.add   = slv.add;
  assign m_ctrl.wen   = slv.wen;
  assign m_ctrl.wdata = slv.wdata;
  assign m_ctrl.id    = slv.id;

  assign m_tmr.req    = slv.req && (sel == SLV_TIMER);
  assign m_tmr.add    = slv.add;
  assign m_tmr.wen    = slv.wen;
  assign m_tmr.wdata  = slv.wdata;
  assign m_tmr.id     = slv.id;

  assign m_evt.req    = slv.req && (sel == SLV_EVENT);
  assign m_evt.add    = slv.add;
  assign m_evt.wen    = slv.wen;
  assign m_evt.wdata  = slv.wdata;
  assign m_evt.id     = slv.id;

  // Unmapped region grants at once
  always_comb begin
    case (sel)
      SLV_CTRL:  slv.gnt = slv.req && m_ctrl.gnt;
      SLV_TIMER: slv.gnt = slv.req && m_tmr.gnt;
      SLV_EVENT: slv.gnt = slv.req && m_evt.gnt;
      default:   slv.gnt = slv.req;
    endcase
  end

  // Remember where the accepted request went
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= SLV_CTRL;
      unm_q <= 1'b0;
    end else begin
      unm_q <= slv.req && slv.gnt && (sel == SLV_NONE);
      if (slv.req && slv.gnt) begin
        sel_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv.req && slv.gnt) begin
      unm_wen_q <= slv.wen;
      unm_id_q  <= slv.id;
    end
  end

  //************************************************************
  // Response merge
  //************************************************************
  always_comb begin
    case (sel_q)
      SLV_CTRL: begin
        slv.r_valid = m_ctrl.r_valid;
        slv.r_rdata = m_ctrl.r_rdata;
        slv.r_id    = m_ctrl.r_id;
      end
      SLV_TIMER: begin
        slv.r_valid = m_tmr.r_valid;
        slv.r_rdata = m_tmr.r_rdata;
        slv.r_id    = m_tmr.r_id;
      end
      SLV_EVENT: begin
        slv.r_valid = m_evt.r_valid;
        slv.r_rdata = m_evt.r_rdata;
        slv.r_id    = m_evt.r_id;
      end
      default: begin
        slv.r_valid = unm_q;
        slv.r_rdata = unm_wen_q ? UNMAPPED_RDATA : '0;
        slv.r_id    = unm_id_q;
      end
    endcase
  end

  // Every response belongs to a request accepted one cycle earlier
  a_rsp_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    slv.r_valid |-> $past(slv.req && slv.gnt));

endmodule

// ==== verilog/periph_bus_if.sv ====
// Peripheral bus interface
interface periph_bus_if;
  import cluster_pkg::*;

  // Request channel, req is valid and gnt is ready
  logic    req;
  word_t   add;
  logic    wen;
  word_t   wdata;
  per_id_t id;
  logic    gnt;

  // Response channel, always accepted by the master
  logic    r_valid;
  word_t   r_rdata;
  per_id_t r_id;

  modport master (
    output req, add, wen, wdata, id,
    input  gnt, r_valid, r_rdata, r_id
  );

  modport slave (
    input  req, add, wen, wdata, id,
    output gnt, r_valid, r_rdata, r_id
  );

endinterface

// ==== verilog/periph_map_pkg.sv ====
// Peripheral address map
package periph_map_pkg;

  // Slave selection field sits at address bits 11:10
  localparam int SLV_SEL_LSB = 10;

  typedef logic [1:0] slave_sel_t;

  localparam slave_sel_t SLV_CTRL  = 2'd0;
  localparam slave_sel_t SLV_TIMER = 2'd1;
  localparam slave_sel_t SLV_EVENT = 2'd2;
  localparam slave_sel_t SLV_NONE  = 2'd3;

  localparam cluster_pkg::word_t UNMAPPED_RDATA = 32'hDEAD_B33F;

  // Byte offset inside one slave window (1 KiB)
  typedef logic [SLV_SEL_LSB-1:0] offs_t;

  // Control unit
  localparam offs_t CTRL_EOC       = 10'h000;
  localparam offs_t CTRL_FETCH_EN  = 10'h008;
  localparam offs_t CTRL_BOOT_ADDR = 10'h040;

  // Timer
  localparam offs_t TMR_CFG   = 10'h000;
  localparam offs_t TMR_COUNT = 10'h004;
  localparam offs_t TMR_CMP   = 10'h008;

  // Event unit
  localparam offs_t EU_MASK    = 10'h000;
  localparam offs_t EU_PENDING = 10'h040;
  localparam offs_t EU_CLEAR   = 10'h044;
  localparam offs_t EU_SOC_ID  = 10'h048;

endpackage
